/* common/lock_pkg.sv */
`default_nettype none

package lock_pkg;

    // keypad word from the upstream scanner
    localparam int KEY_WIDTH = 16;

    // one-hot bit positions
    localparam int KEY_BIT_ENTER     = 0;
    localparam int KEY_BIT_CLEAR_ALL = 8;
    localparam int KEY_BIT_CLEAR     = 12;

    // bit position of digits 0..9, indexed by digit value
    localparam int KEY_DIGIT_BIT [10] = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};

    typedef enum logic [1:0] {
        key_digit,
        key_enter,
        key_clear,      // clear-entry
        key_clear_all
    } key_kind_t;

    typedef logic [3:0] digit_t;   // one bcd digit

    // three nibbles, oldest digit on top
    typedef logic [11:0] disp_t;

    localparam digit_t NIBBLE_BLANK = 4'hF;   // dark position
    localparam disp_t  DISP_BLANK   = {3{NIBBLE_BLANK}};
    localparam disp_t  DISP_PASS    = 12'hBCC;
    localparam disp_t  DISP_LOCKED  = 12'h000;

    // entry length
    localparam int CODE_DIGITS = 3;
    localparam int COUNT_W     = 2;   // fits 0..CODE_DIGITS

endpackage

`default_nettype wire

/* common/tone_pkg.sv */
`default_nettype none

package tone_pkg;

    typedef enum logic [1:0] {
        tone_click,   // accepted digit
        tone_pass,    // code matched
        tone_fail     // wrong code
    } tone_kind_t;

    // defaults in clock cycles for a 50 MHz clock
    localparam int CLICK_HALF = 50000;
    localparam int CLICK_LEN  = 10000000;

    localparam int PASS_HALF  = 25000;
    localparam int PASS_LEN   = 30000000;

    localparam int FAIL_HALF  = 100000;
    localparam int FAIL_LEN   = 3000000;

    // silent window inside the fail pattern
    localparam int FAIL_GAP_START = 1000000;
    localparam int FAIL_GAP_END   = 2000000;

    localparam int TONE_CNT_W = 32;

endpackage

`default_nettype wire

/* logic/key_decode.sv */
`default_nettype none

module key_decode import lock_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [KEY_WIDTH-1:0] onehot,
    output logic                 key_valid,
    output key_kind_t            key_kind,
    output digit_t               key_digit
);

    logic [KEY_WIDTH-1:0] onehot_q;   // sampled keypad word
    logic [KEY_WIDTH-1:0] prev_q;     // word one cycle earlier
    logic                 dec_hit;
    key_kind_t            dec_kind;
    digit_t               dec_digit;

    // map a single-hot code to kind and digit, anything else misses
    always_comb begin
        dec_hit   = 1'b0;
        dec_kind  = lock_pkg::key_digit;
        dec_digit = '0;
        for (int i = 0; i < 10; i++) begin
            if (onehot_q == (KEY_WIDTH'(1) << KEY_DIGIT_BIT[i])) begin
                dec_hit   = 1'b1;
                dec_digit = digit_t'(i);
            end
        end
        if (onehot_q == (KEY_WIDTH'(1) << KEY_BIT_ENTER)) begin
            dec_hit  = 1'b1;
            dec_kind = key_enter;
        end
        if (onehot_q == (KEY_WIDTH'(1) << KEY_BIT_CLEAR)) begin
            dec_hit  = 1'b1;
            dec_kind = key_clear;
        end
        if (onehot_q == (KEY_WIDTH'(1) << KEY_BIT_CLEAR_ALL)) begin
            dec_hit  = 1'b1;
            dec_kind = key_clear_all;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            onehot_q  <= '0;
            prev_q    <= '0;
            key_valid <= 1'b0;
        end else begin
            onehot_q  <= onehot;
            prev_q    <= onehot_q;
            key_valid <= dec_hit && (onehot_q != prev_q);   // fresh press only
        end
    end

    always_ff @(posedge clk) begin
        if (dec_hit && (onehot_q != prev_q)) begin
            key_kind  <= dec_kind;
            key_digit <= dec_digit;
        end
    end

    // upstream debounce keeps every key level for at least one cycle
    a_valid_single: assert property (@(posedge clk) disable iff (!rst_n)
        key_valid |=> !key_valid);

endmodule

`default_nettype wire

/* lock/lock_execute.sv */
`default_nettype none

module lock_execute import lock_pkg::*, tone_pkg::*; #(
    parameter disp_t SECRET    = 12'h246,
    parameter int    MAX_TRIES = 6
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       key_valid,
    input  key_kind_t  key_kind,
    input  digit_t     key_digit,
    output disp_t      display,
    output logic [2:0] tries,
    output logic       unlocked,
    output logic       locked,
    output logic       tone_start,
    output tone_kind_t tone_kind
);

    localparam int CNT_W = COUNT_W + 1;

    logic [CNT_W-1:0] count;       // digits entered so far
    logic [2:0]       tries_next;
    logic             entry_full;

    assign tries_next = tries + 3'd1;
    assign entry_full = (count == CNT_W'(CODE_DIGITS));

    // display doubles as the entry register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            display    <= DISP_BLANK;
            count      <= '0;
            tries      <= '0;
            unlocked   <= 1'b0;
            locked     <= 1'b0;
            tone_start <= 1'b0;
        end else begin
            tone_start <= 1'b0;
            if (key_valid) begin
                case (key_kind)
                    lock_pkg::key_digit: begin
                        if (!entry_full && !unlocked && !locked) begin
                            display    <= {display[7:0], key_digit};   // shift left a nibble
                            count      <= count + 1'b1;
                            tone_start <= 1'b1;
                        end
                    end
                    key_enter: begin
                        if (entry_full && !unlocked && !locked) begin
                            tone_start <= 1'b1;
                            if (display == SECRET) begin
                                unlocked <= 1'b1;
                                display  <= DISP_PASS;
                            end else begin
                                display <= DISP_BLANK;
                                count   <= '0;
                                tries   <= tries_next;
                                if (tries_next == 3'(MAX_TRIES)) begin
                                    locked  <= 1'b1;
                                    display <= DISP_LOCKED;
                                end
                            end
                        end
                    end
                    key_clear: begin
                        if (!locked) begin
                            display  <= DISP_BLANK;
                            count    <= '0;
                            unlocked <= 1'b0;
                        end
                    end
                    default: begin   // clear-all, the only way out of lockout
                        display  <= DISP_BLANK;
                        count    <= '0;
                        unlocked <= 1'b0;
                        tries    <= '0;
                        locked   <= 1'b0;
                    end
                endcase
            end
        end
    end

    // tone pattern follows the same decision as the state update
    always_ff @(posedge clk) begin
        if (key_valid) begin
            if (key_kind == key_enter) begin
                tone_kind <= (display == SECRET) ? tone_pass : tone_fail;
            end else begin
                tone_kind <= tone_click;
            end
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= CNT_W'(CODE_DIGITS));

    a_lock_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(unlocked && locked));

endmodule

`default_nettype wire

/* logic/tone_gen.sv */
`default_nettype none

module tone_gen import tone_pkg::*; #(
    parameter int CLICK_HALF_P     = CLICK_HALF,
    parameter int CLICK_LEN_P      = CLICK_LEN,
    parameter int PASS_HALF_P      = PASS_HALF,
    parameter int PASS_LEN_P       = PASS_LEN,
    parameter int FAIL_HALF_P      = FAIL_HALF,
    parameter int FAIL_LEN_P       = FAIL_LEN,
    parameter int FAIL_GAP_START_P = FAIL_GAP_START,
    parameter int FAIL_GAP_END_P   = FAIL_GAP_END
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tone_start,
    input  tone_kind_t tone_kind,
    output logic       buzzer,
    output logic       tone_busy
);

    logic [TONE_CNT_W-1:0] half_cnt;   // cycles since last toggle
    logic [TONE_CNT_W-1:0] len_cnt;    // cycles since start
    logic [TONE_CNT_W-1:0] half_lim;
    logic [TONE_CNT_W-1:0] len_lim;
    logic                  is_fail;
    logic                  in_gap;

    assign in_gap = is_fail && (len_cnt > TONE_CNT_W'(FAIL_GAP_START_P))
                            && (len_cnt < TONE_CNT_W'(FAIL_GAP_END_P));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buzzer    <= 1'b0;
            tone_busy <= 1'b0;
            half_cnt  <= '0;
            len_cnt   <= '0;
            half_lim  <= '0;
            len_lim   <= '0;
            is_fail   <= 1'b0;
        end else if (tone_start) begin
            // restart whatever is playing
            half_cnt  <= '0;
            len_cnt   <= '0;
            buzzer    <= 1'b1;
            tone_busy <= 1'b1;
            is_fail   <= (tone_kind == tone_fail);
            case (tone_kind)
                tone_pass: begin
                    half_lim <= TONE_CNT_W'(PASS_HALF_P);
                    len_lim  <= TONE_CNT_W'(PASS_LEN_P);
                end
                tone_fail: begin
                    half_lim <= TONE_CNT_W'(FAIL_HALF_P);
                    len_lim  <= TONE_CNT_W'(FAIL_LEN_P);
                end
                default: begin
                    half_lim <= TONE_CNT_W'(CLICK_HALF_P);
                    len_lim  <= TONE_CNT_W'(CLICK_LEN_P);
                end
            endcase
        end else if (tone_busy) begin
            half_cnt <= half_cnt + 1'b1;
            len_cnt  <= len_cnt + 1'b1;
            if (half_cnt >= half_lim) begin
                buzzer   <= ~buzzer;
                half_cnt <= '0;
            end
            if (in_gap) begin
                buzzer <= 1'b0;   // broken tone
            end
            if (len_cnt >= len_lim) begin   // pattern done
                tone_busy <= 1'b0;
                buzzer    <= 1'b0;
            end
        end
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !tone_busy |-> !buzzer);

endmodule

`default_nettype wire

/* logic/code_lock_top.sv */
`default_nettype none

module code_lock_top import lock_pkg::*, tone_pkg::*; #(
    parameter disp_t SECRET         = 12'h246,
    parameter int    MAX_TRIES      = 6,
    parameter int    CLICK_HALF_P     = CLICK_HALF,
    parameter int    CLICK_LEN_P      = CLICK_LEN,
    parameter int    PASS_HALF_P      = PASS_HALF,
    parameter int    PASS_LEN_P       = PASS_LEN,
    parameter int    FAIL_HALF_P      = FAIL_HALF,
    parameter int    FAIL_LEN_P       = FAIL_LEN,
    parameter int    FAIL_GAP_START_P = FAIL_GAP_START,
    parameter int    FAIL_GAP_END_P   = FAIL_GAP_END
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [KEY_WIDTH-1:0] onehot,
    output disp_t                display,
    output logic [2:0]           tries,
    output logic                 unlocked,
    output logic                 locked,
    output logic                 buzzer,
    output logic                 tone_busy
);

    logic       key_valid;
    key_kind_t  key_kind;
    digit_t     key_digit;
    logic       tone_start;
    tone_kind_t tone_kind;

    key_decode key_decode_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .onehot    (onehot),
        .key_valid (key_valid),
        .key_kind  (key_kind),
        .key_digit (key_digit)
    );

    lock_execute #(
        .SECRET    (SECRET),
        .MAX_TRIES (MAX_TRIES)
    ) lock_execute_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .key_valid  (key_valid),
        .key_kind   (key_kind),
        .key_digit  (key_digit),
        .display    (display),
        .tries      (tries),
        .unlocked   (unlocked),
        .locked     (locked),
        .tone_start (tone_start),
        .tone_kind  (tone_kind)
    );

    tone_gen #(
        .CLICK_HALF_P     (CLICK_HALF_P),
        .CLICK_LEN_P      (CLICK_LEN_P),
        .PASS_HALF_P      (PASS_HALF_P),
        .PASS_LEN_P       (PASS_LEN_P),
        .FAIL_HALF_P      (FAIL_HALF_P),
        .FAIL_LEN_P       (FAIL_LEN_P),
        .FAIL_GAP_START_P (FAIL_GAP_START_P),
        .FAIL_GAP_END_P   (FAIL_GAP_END_P)
    ) tone_gen_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .tone_start (tone_start),
        .tone_kind  (tone_kind),
        .buzzer     (buzzer),
        .tone_busy  (tone_busy)
    );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;   // release away from the rising edge
    end

endmodule

`default_nettype wire

/* verif/tb_code_lock.sv */
`default_nettype none

module tb_code_lock import lock_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD      = 100;
    localparam disp_t SECRET          = 12'h246;
    localparam int    MAX_TRIES       = 6;
    localparam int    LONGEST_TONE    = 40;   // pass pattern length
    localparam int    NUM_KEYS        = 500;
    localparam int    IDLE_EVERY      = 40;   // keys between idle checks
    localparam int    WATCHDOG_CYCLES = NUM_KEYS * 10 + 2000;

    // keypad map, indexed by digit value
    localparam int DIGIT_BIT [10]   = '{3, 7, 6, 5, 11, 10, 9, 15, 14, 13};
    localparam int UNUSED_BIT [3]   = '{1, 2, 4};
    localparam int ENTER_BIT        = 0;
    localparam int CLEAR_BIT        = 12;
    localparam int CLEAR_ALL_BIT    = 8;

    logic        clk;
    logic        rst_n;
    logic [15:0] onehot;
    disp_t       display;
    logic [2:0]  tries;
    logic        unlocked;
    logic        locked;
    logic        buzzer;
    logic        tone_busy;

    // reference model state
    disp_t exp_disp;
    int    exp_count;
    int    exp_tries;
    bit    exp_unlocked;
    bit    exp_locked;
    int    key_count;
    int    keys_since_idle;
    bit    buzzer_seen;   // buzzer went high at least once

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (2)
    ) clk_gen_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    code_lock_top #(
        .SECRET           (SECRET),
        .MAX_TRIES        (MAX_TRIES),
        .CLICK_HALF_P     (2),
        .CLICK_LEN_P      (20),
        .PASS_HALF_P      (3),
        .PASS_LEN_P       (LONGEST_TONE),
        .FAIL_HALF_P      (4),
        .FAIL_LEN_P       (30),
        .FAIL_GAP_START_P (10),
        .FAIL_GAP_END_P   (20)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .onehot    (onehot),
        .display   (display),
        .tries     (tries),
        .unlocked  (unlocked),
        .locked    (locked),
        .buzzer    (buzzer),
        .tone_busy (tone_busy)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_state(input bit tone);
        check_value("display", 32'(display), 32'(exp_disp));
        check_value("tries", 32'(tries), 32'(exp_tries));
        check_value("unlocked", 32'(unlocked), 32'(exp_unlocked));
        check_value("locked", 32'(locked), 32'(exp_locked));
        if (tone) begin
            check_value("tone_busy", 32'(tone_busy), 32'd1);   // tone started
        end
    endtask

    // hold a word, release it, then compare once the update has landed
    task automatic drive_key(input logic [15:0] word, input bit tone);
        int hold;
        int gap;
        hold = $urandom_range(1, 4);
        gap  = $urandom_range(0, 2);
        onehot = word;
        repeat (hold) @(negedge clk);
        onehot = '0;
        repeat (3) @(negedge clk);   // 2-cycle press latency plus margin
        compare_state(tone);
        repeat (gap) @(negedge clk);
        key_count++;
        keys_since_idle++;
    endtask

    task automatic enter_digit(input int d);
        bit tone;
        tone = 1'b0;
        if (exp_count < CODE_DIGITS && !exp_unlocked && !exp_locked) begin
            exp_disp = {exp_disp[7:0], 4'(d)};   // oldest digit moves up
            exp_count++;
            tone = 1'b1;
        end
        drive_key(16'(1) << DIGIT_BIT[d], tone);
    endtask

    task automatic hit_enter();
        bit tone;
        tone = 1'b0;
        if (exp_count == CODE_DIGITS && !exp_unlocked && !exp_locked) begin
            tone = 1'b1;
            if (exp_disp == SECRET) begin
                exp_unlocked = 1'b1;
                exp_disp     = DISP_PASS;
            end else begin
                exp_disp  = DISP_BLANK;
                exp_count = 0;
                exp_tries++;
                if (exp_tries == MAX_TRIES) begin
                    exp_locked = 1'b1;
                    exp_disp   = DISP_LOCKED;
                end
            end
        end
        drive_key(16'(1) << ENTER_BIT, tone);
    endtask

    task automatic clear_entry();
        if (!exp_locked) begin   // no effect during lockout
            exp_disp     = DISP_BLANK;
            exp_count    = 0;
            exp_unlocked = 1'b0;
        end
        drive_key(16'(1) << CLEAR_BIT, 1'b0);
    endtask

    task automatic clear_all();
        exp_disp     = DISP_BLANK;
        exp_count    = 0;
        exp_unlocked = 1'b0;
        exp_tries    = 0;
        exp_locked   = 1'b0;
        drive_key(16'(1) << CLEAR_ALL_BIT, 1'b0);
    endtask

    // unused single bits or multi-hot words, never an event
    task automatic inject_junk();
        logic [15:0] word;
        if ($urandom_range(0, 1) == 0) begin
            word = 16'(1) << UNUSED_BIT[$urandom_range(0, 2)];
        end else begin
            do begin
                word = 16'($urandom());
            end while ($countones(word) < 2);
        end
        drive_key(word, 1'b0);
    endtask

    task automatic type_code(input disp_t code);
        enter_digit(int'(code[11:8]));
        enter_digit(int'(code[7:4]));
        enter_digit(int'(code[3:0]));
    endtask

    task automatic wrong_code();
        int d0;
        int d1;
        int d2;
        d0 = $urandom_range(0, 9);
        d1 = $urandom_range(0, 9);
        d2 = $urandom_range(0, 9);
        if ({4'(d0), 4'(d1), 4'(d2)} == SECRET) begin
            d2 = (d2 + 1) % 10;
        end
        enter_digit(d0);
        enter_digit(d1);
        enter_digit(d2);
    endtask

    task automatic wait_idle();
        repeat (LONGEST_TONE + 5) @(negedge clk);
        check_value("tone_busy", 32'(tone_busy), 32'd0);   // every tone has ended
        keys_since_idle = 0;
    endtask

    // buzzer stays quiet outside a tone
    always @(negedge clk) begin
        if (rst_n === 1'b1 && tone_busy === 1'b0) begin
            check_value("buzzer", 32'(buzzer), 32'd0);
        end
        if (rst_n === 1'b1 && buzzer === 1'b1) begin
            buzzer_seen = 1'b1;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int pick;
        onehot          = '0;
        exp_disp        = DISP_BLANK;
        exp_count       = 0;
        exp_tries       = 0;
        exp_unlocked    = 1'b0;
        exp_locked      = 1'b0;
        key_count       = 0;
        keys_since_idle = 0;
        buzzer_seen     = 1'b0;
        void'($urandom(14));
        wait (rst_n === 1'b1);
        @(negedge clk);
        compare_state(1'b0);
        check_value("tone_busy", 32'(tone_busy), 32'd0);
        check_value("buzzer", 32'(buzzer), 32'd0);

        // open the lock, digits afterwards change nothing
        type_code(SECRET);
        hit_enter();
        enter_digit(int'($urandom_range(0, 9)));
        clear_entry();

        // walk into lockout, only clear-all gets out
        clear_all();
        repeat (MAX_TRIES) begin
            wrong_code();
            hit_enter();
        end
        enter_digit(int'($urandom_range(0, 9)));
        clear_entry();
        hit_enter();
        clear_all();
        wait_idle();

        while (key_count < NUM_KEYS) begin
            pick = $urandom_range(0, 99);
            if (pick < 10) begin
                type_code(SECRET);
                hit_enter();
            end else if (pick < 22) begin
                wrong_code();
                hit_enter();
            end else if (pick < 25) begin
                clear_all();
            end else if (pick < 33) begin
                inject_junk();
            end else if (pick < 40) begin
                clear_entry();
            end else if (pick < 55) begin
                hit_enter();
            end else begin
                enter_digit(int'($urandom_range(0, 9)));
            end
            if (keys_since_idle >= IDLE_EVERY) begin
                wait_idle();
            end
        end
        wait_idle();
        check_value("buzzer_seen", 32'(buzzer_seen), 32'd1);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
common/lock_pkg.sv
common/tone_pkg.sv
logic/key_decode.sv
lock/lock_execute.sv
logic/tone_gen.sv
logic/code_lock_top.sv
verif/tb_clk_gen.sv
verif/tb_code_lock.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the code lock testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/100ps \
    --top-module tb_code_lock \
    -f sources.f \
    -o sim_code_lock

# the log decides the result, so a fatal stop must not end the script here
./obj_dir/sim_code_lock | tee sim.log

if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi
